// ==== design/noc_mem_pkg.sv ====
/* Shared NoC definitions for the memory tile
 * Flit widths, flit type codes, virtual channel numbers,
 * and the flit data union with its header and word views */

`default_nettype none

package noc_mem_pkg;

   // Flit geometry
   localparam int NOC_DATA_WIDTH = 32;
   localparam int NOC_TYPE_WIDTH = 2;
   localparam int NOC_FLIT_WIDTH = NOC_DATA_WIDTH + NOC_TYPE_WIDTH;  // Type bits on top

   // Virtual channels
   localparam int VCHANNELS   = 3;
   localparam int VC_DMA_REQ  = 0;  // Requests into the tile
   localparam int VC_DMA_RESP = 1;  // Responses out of the tile
   localparam int VC_MPSIMPLE = 2;  // Message passing, unused here

   // Flit type codes
   localparam logic [NOC_TYPE_WIDTH-1:0] FLIT_PAYLOAD = 2'b00;
   localparam logic [NOC_TYPE_WIDTH-1:0] FLIT_HEADER  = 2'b01;
   localparam logic [NOC_TYPE_WIDTH-1:0] FLIT_LAST    = 2'b10;
   localparam logic [NOC_TYPE_WIDTH-1:0] FLIT_SINGLE  = 2'b11;  // Header and last at once

   // Flit data word
   // First flit of a packet is read through hdr, all others through word
   typedef union packed {
      struct packed {
         logic [4:0]  dest;      // Destination tile
         logic [4:0]  src;       // Requesting tile
         logic        write;     // 1 write, 0 read
         logic [2:0]  len_m1;    // Word count minus one
         logic [17:0] reserved;
      } hdr;
      logic [NOC_DATA_WIDTH-1:0] word;  // Address or data
   } flit_data_u;

endpackage

`default_nettype wire

// ==== design/dma_request_parser.sv ====
/* DMA request parser
 * Turns request packets into command FIFO entries,
 * drops misrouted packets and checks the write data length */

`timescale 1ns/10ps
`default_nettype none

module dma_request_parser #(
   parameter logic [4:0] TILE_ID = 5'd0
) (
   input  wire                                      clk,
   input  wire                                      reset_i,
   input  wire  [noc_mem_pkg::NOC_FLIT_WIDTH-1:0]   in_flit_i,
   input  wire                                      in_valid_i,
   output logic                                     in_ready_o,
   output logic                                     push_o,
   output logic [noc_mem_pkg::NOC_FLIT_WIDTH-1:0]   entry_o,
   input  wire                                      full_i,
   output logic                                     misroute_o
);

   import noc_mem_pkg::*;

   typedef enum logic [1:0] {
      P_IDLE,   // Waiting for a header
      P_ADDR,   // Address word next
      P_DATA,   // Write data words
      P_DROP    // Discard until end of packet
   } state_t;

   state_t                      state;
   logic [NOC_TYPE_WIDTH-1:0]   in_type;
   flit_data_u                  in_data;
   logic                        accept;       // Flit moves this cycle
   logic                        tail;         // Flit closes its packet
   logic                        for_us;       // Header addressed to this tile
   logic                        is_write;     // Latched from header
   logic [2:0]                  len_m1;       // Latched from header
   logic [2:0]                  word_cnt;     // Write data words taken so far
   logic                        last_word;

   assign in_type    = in_flit_i[NOC_FLIT_WIDTH-1 -: NOC_TYPE_WIDTH];
   assign in_data    = in_flit_i[NOC_DATA_WIDTH-1:0];
   assign in_ready_o = ~full_i;                 // One entry per flit, so space is enough
   assign accept     = in_valid_i & in_ready_o;
   assign tail       = (in_type == FLIT_LAST) | (in_type == FLIT_SINGLE);
   assign for_us     = (in_data.hdr.dest == TILE_ID);
   assign last_word  = (word_cnt == len_m1);   // Expected final data word

   // Entry build, same cycle as the accepted flit
   always_comb begin
      push_o  = 1'b0;
      entry_o = {FLIT_PAYLOAD, in_data.word};
      case (state)
         P_IDLE: begin
            push_o  = accept & (in_type == FLIT_HEADER) & for_us;
            entry_o = {FLIT_HEADER, in_data.word};
         end
         P_ADDR: begin
            push_o = accept;
            if (is_write & tail)               // Write packet ended without data
               entry_o = {FLIT_LAST, in_data.word};
         end
         P_DATA: begin
            push_o = accept;
            if (tail | last_word)              // Short or long packets end here too
               entry_o = {FLIT_LAST, in_data.word};
         end
         default: begin
            push_o = 1'b0;                     // Dropped flits go nowhere
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state      <= P_IDLE;
         misroute_o <= 1'b0;
         is_write   <= 1'b0;
         len_m1     <= 3'd0;
         word_cnt   <= 3'd0;
      end else begin
         misroute_o <= 1'b0;                   // One cycle pulse
         if (accept) begin
            case (state)
               P_IDLE: begin
                  if ((in_type == FLIT_HEADER) || (in_type == FLIT_SINGLE)) begin
                     if (!for_us)
                        misroute_o <= 1'b1;
                     if ((in_type == FLIT_HEADER) && for_us) begin
                        is_write <= in_data.hdr.write;
                        len_m1   <= in_data.hdr.len_m1;
                        state    <= P_ADDR;
                     end else if (in_type == FLIT_HEADER) begin
                        state <= P_DROP;       // Rest of a misrouted packet
                     end
                  end
               end
               P_ADDR: begin
                  word_cnt <= 3'd0;
                  if (tail)
                     state <= P_IDLE;
                  else if (is_write)
                     state <= P_DATA;
                  else
                     state <= P_DROP;          // Read carries nothing past the address
               end
               P_DATA: begin
                  word_cnt <= word_cnt + 3'd1;
                  if (tail)
                     state <= P_IDLE;
                  else if (last_word)
                     state <= P_DROP;          // Surplus words discarded
               end
               default: begin
                  if (tail)
                     state <= P_IDLE;
               end
            endcase
         end
      end
   end

   // Data word count never runs past the header length
   assert property (@(posedge clk) disable iff (reset_i)
      (state == P_DATA) |-> (word_cnt <= len_m1))
      else $error("parser data count past len_m1");

endmodule

`default_nettype wire

// ==== design/dma_command_fifo.sv ====
/* Command FIFO between request parser and Wishbone responder
 * Register array with wrap-bit pointers, head entry shown combinationally */

`timescale 1ns/10ps
`default_nettype none

module dma_command_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  wire                                      clk,
   input  wire                                      reset_i,
   input  wire                                      push_i,
   input  wire  [noc_mem_pkg::NOC_FLIT_WIDTH-1:0]   entry_i,
   output logic                                     full_o,
   input  wire                                      pop_i,
   output logic [noc_mem_pkg::NOC_FLIT_WIDTH-1:0]   entry_o,
   output logic                                     empty_o
);

   import noc_mem_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);   // Index width

   logic [NOC_FLIT_WIDTH-1:0] mem [FIFO_DEPTH];
   logic [AW:0]               wr_ptr;        // Extra top bit marks wrap
   logic [AW:0]               rd_ptr;

   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) &&
                    (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);  // Same slot, one lap apart
   assign entry_o = mem[rd_ptr[AW-1:0]];                 // Head entry

   // Pointers
   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (push_i)
         mem[wr_ptr[AW-1:0]] <= entry_i;
   end

   assert property (@(posedge clk) disable iff (reset_i) !(push_i && full_o))
      else $error("FIFO push while full");

   assert property (@(posedge clk) disable iff (reset_i) !(pop_i && empty_o))
      else $error("FIFO pop while empty");

endmodule

`default_nettype wire

// ==== design/dma_wb_responder.sv ====
/* Wishbone responder for DMA commands
 * Runs single Wishbone accesses per command entry,
 * sends write acknowledge or read data packets back */

`timescale 1ns/10ps
`default_nettype none

module dma_wb_responder #(
   parameter logic [4:0] TILE_ID = 5'd0
) (
   input  wire                                      clk,
   input  wire                                      reset_i,
   input  wire  [noc_mem_pkg::NOC_FLIT_WIDTH-1:0]   entry_i,
   input  wire                                      empty_i,
   output logic                                     pop_o,
   output logic                                     wb_cyc_o,
   output logic                                     wb_stb_o,
   output logic                                     wb_we_o,
   output logic [31:0]                              wb_adr_o,
   output logic [31:0]                              wb_dat_o,
   input  wire                                      wb_ack_i,
   input  wire                                      wb_err_i,
   input  wire  [31:0]                              wb_dat_i,
   output logic [noc_mem_pkg::NOC_FLIT_WIDTH-1:0]   out_flit_o,
   output logic                                     out_valid_o,
   input  wire                                      out_ready_i
);

   import noc_mem_pkg::*;

   typedef enum logic [3:0] {
      R_IDLE,      // Wait for command header
      R_ADDR,      // Take address entry
      R_WR,        // Start write with next data entry
      R_WR_WAIT,   // Write in flight
      R_ACK,       // Single flit acknowledge out
      R_RD_HDR,    // Read response header out
      R_RD_REQ,    // Wait for output room, then read
      R_RD_WAIT,   // Read in flight
      R_RD_SEND    // Read word on the NoC
   } state_t;

   state_t                      state;
   flit_data_u                  req_hdr;      // Command header
   flit_data_u                  resp_hdr;
   logic [NOC_TYPE_WIDTH-1:0]   entry_type;
   logic [29:0]                 word_addr;
   logic [2:0]                  rd_cnt;       // Read words sent
   logic                        wr_last;      // Current write closes the command
   logic                        wb_done;

   assign entry_type = entry_i[NOC_FLIT_WIDTH-1 -: NOC_TYPE_WIDTH];
   assign wb_done    = wb_ack_i | wb_err_i;     // Error still completes the access
   assign wb_adr_o   = {word_addr, 2'b00};      // Byte address
   assign pop_o      = ~empty_i & ((state == R_IDLE) | (state == R_ADDR) | (state == R_WR));

   // Response header, back to the requester
   always_comb begin
      resp_hdr            = '0;
      resp_hdr.hdr.dest   = req_hdr.hdr.src;
      resp_hdr.hdr.src    = TILE_ID;
      resp_hdr.hdr.write  = req_hdr.hdr.write;
      resp_hdr.hdr.len_m1 = req_hdr.hdr.len_m1;
   end

   // Control
   always_ff @(posedge clk) begin
      if (reset_i) begin
         state       <= R_IDLE;
         wb_cyc_o    <= 1'b0;
         wb_stb_o    <= 1'b0;
         wb_we_o     <= 1'b0;
         out_valid_o <= 1'b0;
      end else begin
         case (state)
            R_IDLE: if (!empty_i && (entry_type == FLIT_HEADER)) state <= R_ADDR;
            R_ADDR: if (!empty_i) begin
               if (!req_hdr.hdr.write) begin
                  state       <= R_RD_HDR;
                  out_valid_o <= 1'b1;
               end else if (entry_type == FLIT_LAST) begin
                  state       <= R_ACK;        // No data words came
                  out_valid_o <= 1'b1;
               end else begin
                  state <= R_WR;
               end
            end
            R_WR: if (!empty_i) begin
               wb_cyc_o <= 1'b1;
               wb_stb_o <= 1'b1;
               wb_we_o  <= 1'b1;
               state    <= R_WR_WAIT;
            end
            R_WR_WAIT: if (wb_done) begin
               wb_cyc_o <= 1'b0;
               wb_stb_o <= 1'b0;
               if (wr_last) begin
                  state       <= R_ACK;
                  out_valid_o <= 1'b1;
               end else begin
                  state <= R_WR;
               end
            end
            R_ACK, R_RD_HDR: if (out_ready_i) begin
               out_valid_o <= 1'b0;
               state       <= (state == R_ACK) ? R_IDLE : R_RD_REQ;
            end
            R_RD_REQ: if (out_ready_i) begin  // Room downstream before reading
               wb_cyc_o <= 1'b1;
               wb_stb_o <= 1'b1;
               wb_we_o  <= 1'b0;
               state    <= R_RD_WAIT;
            end
            R_RD_WAIT: if (wb_done) begin
               wb_cyc_o    <= 1'b0;
               wb_stb_o    <= 1'b0;
               out_valid_o <= 1'b1;
               state       <= R_RD_SEND;
            end
            R_RD_SEND: if (out_ready_i) begin
               out_valid_o <= 1'b0;
               state       <= (rd_cnt == req_hdr.hdr.len_m1) ? R_IDLE : R_RD_REQ;
            end
            default: state <= R_IDLE;
         endcase
      end
   end

   // Datapath
   always_ff @(posedge clk) begin
      case (state)
         R_IDLE: if (!empty_i) req_hdr <= entry_i[NOC_DATA_WIDTH-1:0];
         R_ADDR: if (!empty_i) begin
            word_addr  <= entry_i[29:0];
            rd_cnt     <= 3'd0;
            out_flit_o <= {req_hdr.hdr.write ? FLIT_SINGLE : FLIT_HEADER, resp_hdr.word};
         end
         R_WR: if (!empty_i) begin
            wb_dat_o <= entry_i[NOC_DATA_WIDTH-1:0];
            wr_last  <= (entry_type == FLIT_LAST);
         end
         R_WR_WAIT: if (wb_done) word_addr <= word_addr + 30'd1;
         R_RD_WAIT: if (wb_done) begin
            word_addr  <= word_addr + 30'd1;
            out_flit_o <= {(rd_cnt == req_hdr.hdr.len_m1) ? FLIT_LAST : FLIT_PAYLOAD, wb_dat_i};
         end
         R_RD_SEND: if (out_ready_i) rd_cnt <= rd_cnt + 3'd1;
         default: ;
      endcase
   end

   // Request held until slave answers
   assert property (@(posedge clk) disable iff (reset_i)
      wb_cyc_o && !wb_done |=> wb_cyc_o && $stable(wb_adr_o) && $stable(wb_we_o))
      else $error("Wishbone request changed before ack");

   // Flit held under back-pressure
   assert property (@(posedge clk) disable iff (reset_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_flit_o))
      else $error("response flit changed before acceptance");

endmodule

`default_nettype wire

// ==== design/memory_tile_dm.sv ====
/* Memory tile top level
 * Request parser, command FIFO and Wishbone responder,
 * virtual channel split and ties for the unused channels */

`timescale 1ns/10ps
`default_nettype none

module memory_tile_dm #(
   parameter logic [4:0] TILE_ID    = 5'd0,
   parameter int         FIFO_DEPTH = 16    // Power of two
) (
   input  wire                                     clk,
   input  wire                                     reset_i,
   // NoC input
   input  wire  [noc_mem_pkg::NOC_FLIT_WIDTH-1:0]  noc_in_flit_i,
   input  wire  [noc_mem_pkg::VCHANNELS-1:0]       noc_in_valid_i,
   output wire  [noc_mem_pkg::VCHANNELS-1:0]       noc_in_ready_o,
   // NoC output
   output wire  [noc_mem_pkg::NOC_FLIT_WIDTH-1:0]  noc_out_flit_o,
   output wire  [noc_mem_pkg::VCHANNELS-1:0]       noc_out_valid_o,
   input  wire  [noc_mem_pkg::VCHANNELS-1:0]       noc_out_ready_i,
   // Wishbone master
   output wire                                     wb_cyc_o,
   output wire                                     wb_stb_o,
   output wire                                     wb_we_o,
   output wire  [31:0]                             wb_adr_o,
   output wire  [31:0]                             wb_dat_o,
   input  wire                                     wb_ack_i,
   input  wire                                     wb_err_i,
   input  wire  [31:0]                             wb_dat_i,
   // Status
   output wire                                     misroute_o
);

   import noc_mem_pkg::*;

   wire                       fifo_push;    // Parser to FIFO
   wire                       fifo_full;
   wire [NOC_FLIT_WIDTH-1:0]  push_entry;
   wire                       fifo_pop;     // FIFO to responder
   wire                       fifo_empty;
   wire [NOC_FLIT_WIDTH-1:0]  head_entry;

   // Tile is a pure target
   assign noc_out_valid_o[VC_DMA_REQ]  = 1'b0;   // Never requests
   assign noc_in_ready_o[VC_DMA_RESP]  = 1'b0;   // So never gets responses
   assign noc_out_valid_o[VC_MPSIMPLE] = 1'b0;   // No message passing
   assign noc_in_ready_o[VC_MPSIMPLE]  = 1'b0;

   dma_request_parser #(.TILE_ID(TILE_ID)) parser_inst (
      .clk        (clk),
      .reset_i    (reset_i),
      .in_flit_i  (noc_in_flit_i),
      .in_valid_i (noc_in_valid_i[VC_DMA_REQ]),
      .in_ready_o (noc_in_ready_o[VC_DMA_REQ]),
      .push_o     (fifo_push),
      .entry_o    (push_entry),
      .full_i     (fifo_full),
      .misroute_o (misroute_o)
   );

   dma_command_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_inst (
      .clk     (clk),
      .reset_i (reset_i),
      .push_i  (fifo_push),
      .entry_i (push_entry),
      .full_o  (fifo_full),
      .pop_i   (fifo_pop),
      .entry_o (head_entry),
      .empty_o (fifo_empty)
   );

   dma_wb_responder #(.TILE_ID(TILE_ID)) responder_inst (
      .clk         (clk),
      .reset_i     (reset_i),
      .entry_i     (head_entry),
      .empty_i     (fifo_empty),
      .pop_o       (fifo_pop),
      .wb_cyc_o    (wb_cyc_o),
      .wb_stb_o    (wb_stb_o),
      .wb_we_o     (wb_we_o),
      .wb_adr_o    (wb_adr_o),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_i    (wb_ack_i),
      .wb_err_i    (wb_err_i),
      .wb_dat_i    (wb_dat_i),
      .out_flit_o  (noc_out_flit_o),
      .out_valid_o (noc_out_valid_o[VC_DMA_RESP]),
      .out_ready_i (noc_out_ready_i[VC_DMA_RESP])
   );

endmodule

`default_nettype wire

// ==== bench/wb_sram_model.sv ====
/* Wishbone slave memory for the testbench
 * 1024 words preloaded from the address, 0 to 3 random wait states */

`timescale 1ns/10ps
`default_nettype none

module wb_sram_model #(
   parameter int SEED = 1
) (
   input  wire         clk,
   input  wire         reset_i,
   input  wire         wb_cyc_i,
   input  wire         wb_stb_i,
   input  wire         wb_we_i,
   input  wire  [31:0] wb_adr_i,
   input  wire  [31:0] wb_dat_i,
   output logic        wb_ack_o,
   output logic        wb_err_o,
   output logic [31:0] wb_dat_o
);

   logic [31:0] mem [1024];
   logic [31:0] wait_left;   // Wait states still to go
   logic        busy;        // Delay already drawn for this access
   integer      seed;

   assign wb_err_o = 1'b0;   // Never faults

   initial begin
      seed = SEED;
      for (int i = 0; i < 1024; i++)
         mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0101);   // Every address bit shows
   end

   always @(posedge clk) begin
      if (reset_i) begin
         wb_ack_o  <= 1'b0;
         busy      <= 1'b0;
         wait_left <= '0;
      end else begin
         wb_ack_o <= 1'b0;                                // Single cycle ack
         if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
            if (!busy) begin
               busy      <= 1'b1;
               wait_left <= $random(seed) & 32'd3;
            end else if (wait_left != 0) begin
               wait_left <= wait_left - 1;
            end else begin
               busy     <= 1'b0;
               wb_ack_o <= 1'b1;
               if (wb_we_i)
                  mem[wb_adr_i[11:2]] <= wb_dat_i;        // Word addressed
               else
                  wb_dat_o <= mem[wb_adr_i[11:2]];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== bench/tb_memory_tile_dm.sv ====
/* Testbench for the memory tile
 * Request packets, reference memory and expected response queue,
 * output back-pressure, assertion checks, watchdog and report */

`timescale 1ns/10ps
`default_nettype none

module tb_memory_tile_dm;

   import noc_mem_pkg::*;

   localparam logic [4:0] TILE_ID     = 5'd9;
   localparam int         FIFO_DEPTH  = 16;
   localparam int         SEED        = 62907;
   localparam int         NUM_PACKETS = 50;
   localparam int         CLK_HALF    = 2;                          // 4 ns period
   localparam int         TIMEOUT_NS  = NUM_PACKETS * 400 * 4 + 2000;  // 400 cycles per packet

   logic                      clk;
   logic                      reset_i;
   logic [NOC_FLIT_WIDTH-1:0] noc_in_flit;
   logic [VCHANNELS-1:0]      noc_in_valid;
   wire  [VCHANNELS-1:0]      noc_in_ready;
   wire  [NOC_FLIT_WIDTH-1:0] noc_out_flit;
   wire  [VCHANNELS-1:0]      noc_out_valid;
   logic [VCHANNELS-1:0]      noc_out_ready;
   wire                       wb_cyc;
   wire                       wb_stb;
   wire                       wb_we;
   wire                       wb_ack;
   wire                       wb_err;
   wire  [31:0]               wb_adr;
   wire  [31:0]               wb_dat_w;     // Master to slave
   wire  [31:0]               wb_dat_r;     // Slave to master
   wire                       misroute;

   logic [31:0]               ref_mem [int];   // Reference memory by word address
   logic [NOC_FLIT_WIDTH-1:0] exp_q [$];       // Predicted response flits
   logic [NOC_FLIT_WIDTH-1:0] exp_flit;
   int        mon_errors = 0;
   int        prop_errors = 0;
   int        chk_errors = 0;
   int        resp_checked = 0;
   int        wb_accesses = 0;
   int        exp_accesses = 0;
   int        misroutes = 0;
   int        exp_misroutes = 0;
   int        out_mode = 0;                    // 0 ready, 1 random, 2 held low
   integer    stim_seed = SEED;
   integer    ready_seed = SEED ^ 32'h0000_5555;
   logic      req_ready_dropped = 1'b0;

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   memory_tile_dm #(.TILE_ID(TILE_ID), .FIFO_DEPTH(FIFO_DEPTH)) memory_tile_dm_inst (
      .clk(clk), .reset_i(reset_i),
      .noc_in_flit_i(noc_in_flit), .noc_in_valid_i(noc_in_valid), .noc_in_ready_o(noc_in_ready),
      .noc_out_flit_o(noc_out_flit), .noc_out_valid_o(noc_out_valid),
      .noc_out_ready_i(noc_out_ready),
      .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
      .wb_dat_o(wb_dat_w), .wb_ack_i(wb_ack), .wb_err_i(wb_err), .wb_dat_i(wb_dat_r),
      .misroute_o(misroute)
   );

   wb_sram_model #(.SEED(SEED + 1)) sram_inst (
      .clk(clk), .reset_i(reset_i), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_ack_o(wb_ack), .wb_err_o(wb_err),
      .wb_dat_o(wb_dat_r)
   );

   // Contents of a word never written, same rule as the slave preload
   function automatic logic [31:0] mem_word(input int addr);
      if (ref_mem.exists(addr))
         return ref_mem[addr];
      return 32'h5A00_0000 ^ (addr * 32'h0001_0101);
   endfunction

   function automatic logic [31:0] header_word(input logic [4:0] dest, input logic [4:0] src,
                                               input logic write, input logic [2:0] len_m1);
      flit_data_u h;
      h            = '0;
      h.hdr.dest   = dest;
      h.hdr.src    = src;
      h.hdr.write  = write;
      h.hdr.len_m1 = len_m1;
      return h.word;
   endfunction

   // Called on a falling edge, returns on the falling edge after acceptance
   task automatic send_flit(input logic [1:0] ftype, input logic [31:0] data);
      noc_in_flit              = {ftype, data};
      noc_in_valid[VC_DMA_REQ] = 1'b1;
      do
         @(posedge clk);
      while (!noc_in_ready[VC_DMA_REQ]);
      @(negedge clk);
      noc_in_valid[VC_DMA_REQ] = 1'b0;
   endtask

   task automatic send_packet(input logic write, input logic [4:0] dest, input logic [4:0] src,
                              input logic [2:0] len_m1, input int addr);
      logic [31:0] data [8];
      for (int i = 0; i <= len_m1; i++)
         data[i] = $random(stim_seed);
      if (dest == TILE_ID) begin
         exp_accesses += len_m1 + 1;
         if (write) begin
            for (int i = 0; i <= len_m1; i++)
               ref_mem[addr + i] = data[i];
            exp_q.push_back({FLIT_SINGLE, header_word(src, TILE_ID, 1'b1, len_m1)});
         end else begin
            exp_q.push_back({FLIT_HEADER, header_word(src, TILE_ID, 1'b0, len_m1)});
            for (int i = 0; i <= len_m1; i++)
               exp_q.push_back({(i == len_m1) ? FLIT_LAST : FLIT_PAYLOAD, mem_word(addr + i)});
         end
      end else begin
         exp_misroutes++;                                 // Dropped silently
      end
      send_flit(FLIT_HEADER, header_word(dest, src, write, len_m1));
      send_flit(write ? FLIT_PAYLOAD : FLIT_LAST, addr);
      if (write)
         for (int i = 0; i <= len_m1; i++)
            send_flit((i == len_m1) ? FLIT_LAST : FLIT_PAYLOAD, data[i]);
   endtask

   task automatic random_packet(input logic misrouted);
      logic [31:0] r;
      logic [4:0]  dest;
      r    = $random(stim_seed);
      dest = misrouted ? TILE_ID + 5'd1 : TILE_ID;
      send_packet(r[0], dest, r[8:4], r[12:10], int'(r[25:16]) % 1017);  // Stays below 1024
   endtask

   task automatic write_then_read();
      logic [31:0] r;
      int          addr;
      r    = $random(stim_seed);
      addr = int'(r[25:16]) % 1017;
      send_packet(1'b1, TILE_ID, r[8:4], r[12:10], addr);
      send_packet(1'b0, TILE_ID, r[4:0], r[12:10], addr);
   endtask

   task automatic drive_out_ready();
      logic [31:0] r;
      noc_out_ready = '0;
      forever begin
         @(negedge clk);
         r = $random(ready_seed);
         noc_out_ready[VC_DMA_RESP] = (out_mode == 0) || ((out_mode == 1) && (r[1:0] != 2'b00));
      end
   endtask

   initial drive_out_ready();

   // Response, Wishbone and status monitor
   always @(posedge clk) begin
      if (!reset_i) begin
         if ((out_mode == 2) && !noc_in_ready[VC_DMA_REQ])
            req_ready_dropped = 1'b1;                // Drop while output held low
         if (misroute)
            misroutes++;
         if (wb_cyc && wb_stb && (wb_ack || wb_err))
            wb_accesses++;
         if (noc_out_valid[VC_DMA_RESP] && noc_out_ready[VC_DMA_RESP]) begin
            assert (exp_q.size() > 0) else begin
               mon_errors++;
               $display("%0t: response flit %h arrived with nothing expected", $time, noc_out_flit);
            end
            if (exp_q.size() > 0) begin
               exp_flit = exp_q.pop_front();
               resp_checked++;
               assert (noc_out_flit == exp_flit) else begin
                  mon_errors++;
                  $display("[FAIL] %0t noc_out_flit_o: got %h, expected %h",
                           $time, noc_out_flit, exp_flit);
               end
            end
         end
      end
   end

   // Channels the tile never uses
   assert property (@(posedge clk) {noc_out_valid[VC_MPSIMPLE], noc_out_valid[VC_DMA_REQ]} == 2'b00)
      else begin
         prop_errors++;
         $display("[FAIL] %0t noc_out_valid_o: got %b, expected %b", $time, noc_out_valid,
                  {1'b0, noc_out_valid[VC_DMA_RESP], 1'b0});
      end

   assert property (@(posedge clk) {noc_in_ready[VC_MPSIMPLE], noc_in_ready[VC_DMA_RESP]} == 2'b00)
      else begin
         prop_errors++;
         $display("[FAIL] %0t noc_in_ready_o: got %b, expected %b", $time, noc_in_ready,
                  {2'b00, noc_in_ready[VC_DMA_REQ]});
      end

   assert property (@(posedge clk) disable iff (reset_i)
      noc_out_valid[VC_DMA_RESP] && !noc_out_ready[VC_DMA_RESP]
      |=> noc_out_valid[VC_DMA_RESP] && $stable(noc_out_flit))
      else begin
         prop_errors++;
         $display("%0t: response valid dropped or flit changed before acceptance", $time);
      end

   assert property (@(posedge clk) disable iff (reset_i) misroute |=> !misroute)
      else begin
         prop_errors++;
         $display("%0t: misroute_o pulse longer than one cycle", $time);
      end

   initial begin
      reset_i      = 1'b1;
      noc_in_flit  = '0;
      noc_in_valid = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;
      assert (!wb_cyc && !wb_stb && noc_out_valid == '0 && !misroute &&
              memory_tile_dm_inst.fifo_empty) else begin
         chk_errors++;
         $display("Outputs not idle or FIFO not empty after reset");
      end
      repeat (6) write_then_read();                       // Output always ready
      repeat (3) begin
         random_packet(1'b1);
         random_packet(1'b0);
      end
      out_mode = 1;
      repeat (20) random_packet(1'b0);
      out_mode = 2;                                       // Requests pile up
      fork
         for (int k = 0; k < 6; k++)
            send_packet(1'b1, TILE_ID, 5'd3, 3'd7, 100 + 8 * k);
         begin
            repeat (150) @(negedge clk);
            out_mode = 1;
         end
      join
      for (int k = 0; k < 6; k++)
         send_packet(1'b0, TILE_ID, 5'd4, 3'd7, 100 + 8 * k);
      while (exp_q.size() != 0)
         @(negedge clk);
      repeat (20) @(negedge clk);                         // Catch stray responses
      assert (misroutes == exp_misroutes) else begin
         chk_errors++;
         $display("[FAIL] %0t misroute_o pulses: got %0d, expected %0d",
                  $time, misroutes, exp_misroutes);
      end
      assert (wb_accesses == exp_accesses) else begin
         chk_errors++;
         $display("[FAIL] %0t wb_cyc_o accesses: got %0d, expected %0d",
                  $time, wb_accesses, exp_accesses);
      end
      assert (req_ready_dropped) else begin
         chk_errors++;
         $display("Request ready never dropped under output back-pressure");
      end
      foreach (ref_mem[a]) begin
         assert (sram_inst.mem[a] == ref_mem[a]) else begin
            chk_errors++;
            $display("[FAIL] %0t mem[%0d]: got %h, expected %h", $time, a, sram_inst.mem[a],
                     ref_mem[a]);
         end
      end
      $display("Errors: %0d (monitor %0d, properties %0d, final %0d), responses checked: %0d",
               mon_errors + prop_errors + chk_errors, mon_errors, prop_errors, chk_errors,
               resp_checked);
      if (mon_errors + prop_errors + chk_errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/noc_mem_pkg.sv
design/dma_request_parser.sv
design/dma_command_fifo.sv
design/dma_wb_responder.sv
design/memory_tile_dm.sv
bench/wb_sram_model.sv
bench/tb_memory_tile_dm.sv

// ==== Makefile ====
# Verilator simulation of the memory tile

VERILATOR ?= verilator
TOP       ?= tb_memory_tile_dm
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
